/* dv/approx_mac_sva.sv */
`timescale 1ns/10ps

module approx_mac_sva import approx_pkg::*; (
    input logic    clk,
    input logic    rst,
    input logic    in_valid,
    input logic    clear,
    input logic    out_valid,
    input acc_t    acc,
    input errsum_t err_sum,
    input mag_t    err_max,
    input cnt_t    sample_cnt
);

    a_latency: assert property (@(posedge clk) disable iff (rst) in_valid |-> ##2 out_valid)
        else $error("out_valid missing 2 cycles after in_valid");

    a_no_extra: assert property (@(posedge clk) disable iff (rst) out_valid |-> $past(in_valid, 2))
        else $error("out_valid without in_valid 2 cycles earlier");

    a_reset: assert property (@(posedge clk) rst |=> !out_valid && acc == '0 && err_sum == '0
                              && err_max == '0 && sample_cnt == '0)
        else $error("outputs not cleared by reset");

    a_cnt: assert property (@(posedge clk) disable iff (rst)
                            !$stable(sample_cnt) |-> out_valid || $past(clear))
        else $error("sample_cnt changed without a sample or clear");

endmodule

bind approx_mac_top approx_mac_sva i_approx_mac_sva (.*);

/* dv/approx_mac_tb.sv */
`timescale 1ns/10ps

module approx_mac_tb import approx_pkg::*; ();

    logic     clk;
    logic     rst;
    logic     in_valid;
    logic     approx_en;
    logic     clear;
    operand_t x;
    operand_t y;
    logic     out_valid;
    acc_t     acc;
    errsum_t  err_sum;
    mag_t     err_max;
    cnt_t     sample_cnt;

    integer seed = 6;

    // Model state after the next rising edge
    logic     m_pv;
    logic     m_sel;
    product_t m_pa;
    product_t m_pe;
    logic     m_ov;
    acc_t     m_acc;
    errsum_t  m_sum;
    mag_t     m_max;
    cnt_t     m_cnt;

    approx_mac_top i_approx_mac_top (.*);

    always #5 clk = ~clk;

    //////////////////////////////
    // Reference multiplier

    // Baugh-Wooley bit of row r from x[r] and column c from y[c]
    function automatic logic bw(input operand_t a, input operand_t b, input int r, input int c);
        if (c == 16) return (r == 0) || (r == 15);
        if (r == 15) return (c == 15) ? (a[15] & b[15]) : ~(a[15] & b[c]);
        return (c == 15) ? ~(a[r] & b[15]) : (a[r] & b[c]);
    endfunction

    function automatic longint unsigned pand(input operand_t a, input operand_t b,
                                             input int r1, input int c1,
                                             input int r2, input int c2);
        return longint'(bw(a, b, r1, c1) & bw(a, b, r2, c2));
    endfunction

    function automatic longint unsigned pxor(input operand_t a, input operand_t b,
                                             input int r1, input int c1,
                                             input int r2, input int c2);
        return longint'(bw(a, b, r1, c1) ^ bw(a, b, r2, c2));
    endfunction

    function automatic product_t approx_model(input operand_t a, input operand_t b);
        longint unsigned t;
        t = longint'(bw(a, b, 0, 0));
        t += (pxor(a, b, 0, 4, 1, 3) << 4) + (pxor(a, b, 4, 1, 5, 0) << 5);
        t += (pand(a, b, 0, 5, 1, 4) << 6) + (pand(a, b, 0, 6, 1, 5) << 7);
        t += (pxor(a, b, 2, 8, 3, 7) << 10) + (pxor(a, b, 0, 11, 1, 10) << 11);
        t += (pxor(a, b, 4, 8, 5, 7) << 12) + (pxor(a, b, 0, 13, 1, 12) << 13);
        t += (pxor(a, b, 4, 11, 5, 10) << 15) + (pand(a, b, 0, 15, 1, 14) << 16);
        t += (pand(a, b, 1, 15, 0, 16) << 17) + (pand(a, b, 2, 15, 3, 14) << 18);
        t += (pand(a, b, 4, 14, 5, 13) << 19) + (pand(a, b, 4, 15, 5, 14) << 20);
        t += (pand(a, b, 4, 2, 5, 1) << 7) + (pxor(a, b, 4, 7, 5, 6) << 11);
        t += (pxor(a, b, 0, 15, 1, 14) << 15);
        t += (pxor(a, b, 1, 15, 0, 16) << 16) + (pand(a, b, 2, 14, 3, 13) << 17);
        t += (longint'(bw(a, b, 3, 15)) << 18) + (pxor(a, b, 4, 15, 5, 14) << 19);
        t += (longint'(bw(a, b, 5, 15)) << 20);
        t += (pxor(a, b, 2, 14, 3, 13) << 16) + (pxor(a, b, 2, 15, 3, 14) << 17);
        t += (pand(a, b, 4, 13, 5, 12) << 18);
        t += (pand(a, b, 4, 11, 5, 10) << 16) + (pxor(a, b, 4, 13, 5, 12) << 17);
        t += (pxor(a, b, 4, 14, 5, 13) << 18);
        for (int r = 6; r < 16; r++) begin   // Exact upper rows
            for (int c = 0; c < 17; c++) begin
                t += longint'(bw(a, b, r, c)) << (r + c);
            end
        end
        return product_t'(t[31:0]);
    endfunction

    //////////////////////////////
    // Checks and stimulus

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch t=%0t %s got=%h exp=%h", $time, name, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    function automatic operand_t pick_operand();
        int r;
        r = $random(seed);
        if ((r & 7) != 0) return operand_t'($random(seed));
        case ((r >> 3) & 3)
            0: return 16'sd0;
            1: return -16'sd32768;
            2: return 16'sd32767;
            default: return -16'sd1;
        endcase
    endfunction

    // Check state, drive inputs and advance the model by one cycle
    task automatic step(input logic iv, input logic en, input logic cl,
                        input operand_t a, input operand_t b);
        product_t p;
        longint   d;
        @(negedge clk);
        check_val("out_valid", 64'(out_valid), 64'(m_ov));
        check_val("acc", 64'(acc), 64'(m_acc));
        check_val("err_sum", 64'(err_sum), 64'(m_sum));
        check_val("err_max", 64'(err_max), 64'(m_max));
        check_val("sample_cnt", 64'(sample_cnt), 64'(m_cnt));
        rst       = 1'b0;
        in_valid  = iv;
        approx_en = en;
        clear     = cl;
        x         = a;
        y         = b;
        p = m_sel ? m_pa : m_pe;
        d = longint'(m_pe) - longint'(m_pa);
        if (d < 0) d = -d;
        m_ov = m_pv;
        if (cl) begin
            m_acc = m_pv ? acc_t'(p) : '0;
            m_sum = m_pv ? errsum_t'(d) : '0;
            m_max = m_pv ? mag_t'(d) : '0;
            m_cnt = m_pv ? cnt_t'(1) : '0;
        end else if (m_pv) begin
            m_acc = m_acc + acc_t'(p);
            m_sum = m_sum + errsum_t'(d);
            if (mag_t'(d) > m_max) m_max = mag_t'(d);
            m_cnt = m_cnt + cnt_t'(1);
        end
        m_pv = iv;
        if (iv) begin
            // Exact for a zero operand
            m_pa  = (a == 0 || b == 0) ? product_t'(0) : approx_model(a, b);
            m_pe  = product_t'(a) * product_t'(b);
            m_sel = en;
        end
    endtask

    initial begin
        int n;
        clk       = 0;
        rst       = 1;
        in_valid  = 0;
        approx_en = 0;
        clear     = 0;
        x         = '0;
        y         = '0;
        m_pv  = 0;
        m_sel = 0;
        m_pa  = '0;
        m_pe  = '0;
        m_ov  = 0;
        m_acc = '0;
        m_sum = '0;
        m_max = '0;
        m_cnt = '0;
        repeat (4) @(posedge clk);
        step(0, 0, 0, 0, 0);   // Outputs must read zero after reset
        // Directed latency probe
        step(1, 1, 0, 16'sd1234, -16'sd77);
        n = 0;
        while (!out_valid) begin
            step(0, 0, 0, 0, 0);
            n++;
            if (n > 4) begin
                $display("timeout waiting for out_valid on the first sample");
                $display("Checks failed");
                $fatal(1);
            end
        end
        check_val("latency", 64'(n), 64'd2);
        step(0, 0, 1, 0, 0);   // Clear with nothing in flight
        repeat (100) step(1, 1, 0, pick_operand(), pick_operand());
        repeat (100) step(1, 0, 0, pick_operand(), pick_operand());
        step(1, 1, 1, -16'sd1, 16'sd32767);   // Clear alongside a product
        for (int i = 0; i < 2000; i++) begin
            step(($random(seed) % 10 + 10) % 10 < 7, $random(seed) & 1,
                 ($random(seed) & 31) == 0, pick_operand(), pick_operand());
        end
        n = 0;
        while (out_valid || m_ov || m_pv) begin   // Drain the pipeline
            step(0, 0, 0, 0, 0);
            n++;
            if (n > 6) begin
                $display("timeout draining the pipeline");
                $display("Checks failed");
                $fatal(1);
            end
        end
        step(0, 0, 0, 0, 0);
        $display("All checks passed");
        $finish;
    end

endmodule

/* files.f */
+incdir+verilog
verilog/approx_pkg.sv
verilog/approx_mul16.sv
verilog/mul_stage.sv
verilog/mac_accum.sv
verilog/err_stats.sv
verilog/approx_mac_top.sv
dv/approx_mac_sva.sv
dv/approx_mac_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module approx_mac_tb -o sim_tb || exit 1
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "Checks failed" sim.log && exit 1 || grep -q "All checks passed" sim.log && exit 0 || exit 1

/* verilog/approx_cfg.svh */
`ifndef APPROX_CFG_SVH
`define APPROX_CFG_SVH

//////////////////////////////
// Datapath widths

// 256 full-scale products of headroom
`define APPROX_ACC_W    40
`define APPROX_ERRSUM_W 48
`define APPROX_CNT_W    16

`endif

/* verilog/approx_mac_top.sv */
`timescale 1ns/10ps

module approx_mac_top import approx_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  logic     approx_en,
    input  logic     clear,
    input  operand_t x,
    input  operand_t y,
    output logic     out_valid,
    output acc_t     acc,
    output errsum_t  err_sum,
    output mag_t     err_max,
    output cnt_t     sample_cnt
);

    logic     prod_valid;
    logic     prod_sel_approx;
    product_t prod_approx;
    product_t prod_exact;

    mul_stage i_mul_stage (
        .clk             (clk),
        .rst             (rst),
        .in_valid        (in_valid),
        .approx_en       (approx_en),
        .x               (x),
        .y               (y),
        .prod_valid      (prod_valid),
        .prod_sel_approx (prod_sel_approx),
        .prod_approx     (prod_approx),
        .prod_exact      (prod_exact)
    );

    // Both update on the same edge
    mac_accum i_mac_accum (
        .clk             (clk),
        .rst             (rst),
        .clear           (clear),
        .prod_valid      (prod_valid),
        .prod_sel_approx (prod_sel_approx),
        .prod_approx     (prod_approx),
        .prod_exact      (prod_exact),
        .acc             (acc),
        .out_valid       (out_valid)
    );

    err_stats i_err_stats (
        .clk         (clk),
        .rst         (rst),
        .clear       (clear),
        .prod_valid  (prod_valid),
        .prod_approx (prod_approx),
        .prod_exact  (prod_exact),
        .err_sum     (err_sum),
        .err_max     (err_max),
        .sample_cnt  (sample_cnt)
    );

endmodule

/* verilog/approx_mul16.sv */
`timescale 1ns/10ps

module approx_mul16 import approx_pkg::*; (
    input  operand_t x,
    input  operand_t y,
    output product_t z
);

    logic [15:0][16:0] pp;   // Row k at index k-1
    logic [3:0][20:0]  cr;   // Replace rows 1..6
    logic [31:0]       sum;

    //////////////////////////////
    // Baugh-Wooley rows
    always_comb begin
        for (int i = 0; i < 15; i++) begin
            // Bit 16 of row 1 is the low constant one
            pp[i] = {(i == 0), ~(y[15] & x[i]), y[14:0] & {15{x[i]}}};
        end
        // Sign row, inverted magnitude bits and high constant one
        pp[15] = {1'b1, y[15] & x[15], ~(y[14:0] & {15{x[15]}})};
    end

    //////////////////////////////
    // Sparse correction rows
    always_comb begin
        cr = '0;

        cr[0][0]  = pp[0][0];
        cr[0][4]  = pp[0][4] ^ pp[1][3];
        cr[0][5]  = pp[4][1] ^ pp[5][0];
        cr[0][6]  = pp[0][5] & pp[1][4];
        cr[0][7]  = pp[0][6] & pp[1][5];
        cr[0][10] = pp[2][8] ^ pp[3][7];
        cr[0][11] = pp[0][11] ^ pp[1][10];
        cr[0][12] = pp[4][8] ^ pp[5][7];
        cr[0][13] = pp[0][13] ^ pp[1][12];
        cr[0][15] = pp[4][11] ^ pp[5][10];
        cr[0][16] = pp[0][15] & pp[1][14];
        cr[0][17] = pp[1][15] & pp[0][16];   // Carry into the constant one
        cr[0][18] = pp[2][15] & pp[3][14];
        cr[0][19] = pp[4][14] & pp[5][13];
        cr[0][20] = pp[4][15] & pp[5][14];

        cr[1][7]  = pp[4][2] & pp[5][1];
        cr[1][11] = pp[4][7] ^ pp[5][6];
        cr[1][15] = pp[0][15] ^ pp[1][14];
        cr[1][16] = pp[1][15] ^ pp[0][16];   // Sum with the constant one
        cr[1][17] = pp[2][14] & pp[3][13];
        cr[1][18] = pp[3][15];
        cr[1][19] = pp[4][15] ^ pp[5][14];
        cr[1][20] = pp[5][15];

        cr[2][16] = pp[2][14] ^ pp[3][13];
        cr[2][17] = pp[2][15] ^ pp[3][14];
        cr[2][18] = pp[4][13] & pp[5][12];

        cr[3][16] = pp[4][11] & pp[5][10];
        cr[3][17] = pp[4][13] ^ pp[5][12];
        cr[3][18] = pp[4][14] ^ pp[5][13];
    end

    //////////////////////////////
    // Final add
    always_comb begin
        sum = 32'(cr[0]) + 32'(cr[1]) + 32'(cr[2]) + 32'(cr[3]);
        // Rows 7..16 kept exact
        for (int i = 6; i < 16; i++) begin
            sum = sum + (32'(pp[i]) << i);
        end
    end

    assign z = product_t'(sum);

endmodule

/* verilog/approx_pkg.sv */
package approx_pkg;

    `include "approx_cfg.svh"

    // Multiplier operands and products
    typedef logic signed [15:0] operand_t;
    typedef logic signed [31:0] product_t;

    // Accumulator
    typedef logic signed [`APPROX_ACC_W-1:0] acc_t;

    //////////////////////////////
    // Error monitor values

    // Exact minus approx, one bit wider than a product
    typedef logic signed [32:0] err_t;
    typedef logic [32:0] mag_t;
    typedef logic [`APPROX_ERRSUM_W-1:0] errsum_t;
    typedef logic [`APPROX_CNT_W-1:0] cnt_t;

endpackage

/* verilog/err_stats.sv */
`timescale 1ns/10ps

module err_stats import approx_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     clear,
    input  logic     prod_valid,
    input  product_t prod_approx,
    input  product_t prod_exact,
    output errsum_t  err_sum,
    output mag_t     err_max,
    output cnt_t     sample_cnt
);

    err_t    err;
    mag_t    mag;
    errsum_t mag_ext;

    //////////////////////////////
    // Error of this sample
    assign err     = err_t'(prod_exact) - err_t'(prod_approx);
    assign mag     = err[32] ? mag_t'(-err) : mag_t'(err);   // Fits, |err| < 2^32
    assign mag_ext = errsum_t'(mag);

    //////////////////////////////
    // Running statistics
    always_ff @(posedge clk) begin
        if (rst) begin
            err_sum    <= '0;
            err_max    <= '0;
            sample_cnt <= '0;
        end else if (clear) begin
            if (prod_valid) begin
                err_sum    <= mag_ext;
                err_max    <= mag;
                sample_cnt <= cnt_t'(1);
            end else begin
                err_sum    <= '0;
                err_max    <= '0;
                sample_cnt <= '0;
            end
        end else if (prod_valid) begin
            err_sum    <= err_sum + mag_ext;
            sample_cnt <= sample_cnt + cnt_t'(1);   // Wraps
            if (mag > err_max) begin
                err_max <= mag;
            end
        end
    end

endmodule

/* verilog/mac_accum.sv */
`timescale 1ns/10ps

module mac_accum import approx_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     clear,
    input  logic     prod_valid,
    input  logic     prod_sel_approx,
    input  product_t prod_approx,
    input  product_t prod_exact,
    output acc_t     acc,
    output logic     out_valid
);

    product_t prod_sel;
    acc_t     prod_ext;

    assign prod_sel = prod_sel_approx ? prod_approx : prod_exact;
    assign prod_ext = acc_t'(prod_sel);   // Sign extend

    always_ff @(posedge clk) begin
        if (rst) begin
            acc       <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= prod_valid;
            if (clear) begin
                // Restart from this sample if one is here
                acc <= prod_valid ? prod_ext : '0;
            end else if (prod_valid) begin
                acc <= acc + prod_ext;   // Wraps at acc width
            end
        end
    end

endmodule

/* verilog/mul_stage.sv */
`timescale 1ns/10ps

module mul_stage import approx_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  logic     approx_en,
    input  operand_t x,
    input  operand_t y,
    output logic     prod_valid,
    output logic     prod_sel_approx,
    output product_t prod_approx,
    output product_t prod_exact
);

    product_t z_approx;
    product_t z_exact;

    approx_mul16 i_approx_mul16 (
        .x (x),
        .y (y),
        .z (z_approx)
    );

    assign z_exact = x * y;   // Signed, 32-bit context

    always_ff @(posedge clk) begin
        if (rst) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= in_valid;
        end
    end

    // Payload follows the strobe
    always_ff @(posedge clk) begin
        if (in_valid) begin
            prod_approx     <= z_approx;
            prod_exact      <= z_exact;
            prod_sel_approx <= approx_en;
        end
    end

endmodule
